//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int LINK_REG    = 31;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    localparam logic [5:0] OPC_R_TYPE = 6'b000000;
    localparam logic [5:0] OPC_JAL    = 6'b000011;
    localparam logic [5:0] FUNCT_JALR = 6'b001001;

    // how EX picks the alu function
    typedef enum logic [1:0] {
        ALUOP_ADD    = 2'b00,
        ALUOP_IDLE   = 2'b01,
        ALUOP_FUNCT  = 2'b10,
        ALUOP_OPCODE = 2'b11
    } alu_op_e;

    // r-type funct codes and i-type opcodes share one space
    typedef enum logic [5:0] {
        FN_SLL   = 6'b000000,
        FN_SRL   = 6'b000010,
        FN_SRA   = 6'b000011,
        FN_SLLV  = 6'b000100,
        FN_SRLV  = 6'b000110,
        FN_SRAV  = 6'b000111,
        FN_ADDI  = 6'b001000,
        FN_ADDIU = 6'b001001,
        FN_SLTI  = 6'b001010,
        FN_SLTIU = 6'b001011,
        FN_ANDI  = 6'b001100,
        FN_ORI   = 6'b001101,
        FN_XORI  = 6'b001110,
        FN_LUI   = 6'b001111,
        FN_ADD   = 6'b100000,
        FN_ADDU  = 6'b100001,
        FN_SUB   = 6'b100010,
        FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100,
        FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110,
        FN_NOR   = 6'b100111,
        FN_SLT   = 6'b101010,
        FN_SLTU  = 6'b101011,
        FN_IDLE  = 6'b111111
    } alu_func_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

    typedef enum logic [1:0] {
        MW_BYTE = 2'b00,
        MW_HALF = 2'b01,
        MW_WORD = 2'b10
    } mem_width_e;

    typedef struct packed {
        logic    reg_dest;
        logic    alu_src;
        alu_op_e alu_op;
    } ex_ctl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic       is_unsigned;
        mem_width_e width;
    } mem_ctl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctl_t;

    // immediate arrives already extended from decode
    typedef struct packed {
        ex_ctl_t                ex_ctl;
        mem_ctl_t               mem_ctl;
        wb_ctl_t                wb_ctl;
        logic [DATA_W-1:0]      ra;
        logic [DATA_W-1:0]      rb;
        logic [REG_ADDR_W-1:0]  rs;
        logic [REG_ADDR_W-1:0]  rt;
        logic [REG_ADDR_W-1:0]  rd;
        logic [5:0]             funct;
        logic [5:0]             opcode;
        logic [4:0]             shamt;
        logic [DATA_W-1:0]      immediate;
    } id_ex_t;

    typedef struct packed {
        mem_ctl_t               mem_ctl;
        wb_ctl_t                wb_ctl;
        logic [DATA_W-1:0]      alu_result;
        logic [DATA_W-1:0]      store_data;
        logic [REG_ADDR_W-1:0]  reg_dest;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic [REG_ADDR_W-1:0]  reg_dest;
        logic [DATA_W-1:0]      value;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu (
    input  logic [exec_pkg::DATA_W-1:0] i_operand_a,
    input  logic [exec_pkg::DATA_W-1:0] i_operand_b,
    input  exec_pkg::alu_func_e         i_func,
    input  logic [4:0]                  i_shamt,
    output logic [exec_pkg::DATA_W-1:0] o_result
);

    logic [4:0] var_shift;

    // variable shift amount comes from rs
    assign var_shift = i_operand_a[4:0];

    always_comb begin
        case (i_func)
            // shifts act on operand b, like mips rt
            exec_pkg::FN_SLL:   o_result = i_operand_b << i_shamt;
            exec_pkg::FN_SRL:   o_result = i_operand_b >> i_shamt;
            exec_pkg::FN_SRA:   o_result = $signed(i_operand_b) >>> i_shamt;
            exec_pkg::FN_SLLV:  o_result = i_operand_b << var_shift;
            exec_pkg::FN_SRLV:  o_result = i_operand_b >> var_shift;
            exec_pkg::FN_SRAV:  o_result = $signed(i_operand_b) >>> var_shift;

            // no overflow trap, signed and unsigned add the same
            exec_pkg::FN_ADD,
            exec_pkg::FN_ADDU,
            exec_pkg::FN_ADDI,
            exec_pkg::FN_ADDIU: o_result = i_operand_a + i_operand_b;
            exec_pkg::FN_SUB,
            exec_pkg::FN_SUBU:  o_result = i_operand_a - i_operand_b;

            exec_pkg::FN_AND,
            exec_pkg::FN_ANDI:  o_result = i_operand_a & i_operand_b;
            exec_pkg::FN_OR,
            exec_pkg::FN_ORI:   o_result = i_operand_a | i_operand_b;
            exec_pkg::FN_XOR,
            exec_pkg::FN_XORI:  o_result = i_operand_a ^ i_operand_b;
            exec_pkg::FN_NOR:   o_result = ~(i_operand_a | i_operand_b);

            exec_pkg::FN_SLT,
            exec_pkg::FN_SLTI: begin
                o_result = {{(exec_pkg::DATA_W-1){1'b0}},
                            $signed(i_operand_a) < $signed(i_operand_b)};
            end
            exec_pkg::FN_SLTU,
            exec_pkg::FN_SLTIU: begin
                o_result = {{(exec_pkg::DATA_W-1){1'b0}}, i_operand_a < i_operand_b};
            end

            exec_pkg::FN_LUI:   o_result = i_operand_b << 16;

            // idle and anything undefined
            default:            o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/forward_unit.sv
`default_nettype none

module forward_unit (
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rs,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_rt,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_mem_dest,
    input  logic                            i_mem_reg_write,
    input  logic [exec_pkg::REG_ADDR_W-1:0] i_wb_dest,
    input  logic                            i_wb_reg_write,
    output exec_pkg::fwd_sel_e              o_fwd_a,
    output exec_pkg::fwd_sel_e              o_fwd_b
);

    logic mem_live;
    logic wb_live;

    // r0 is never a real producer
    assign mem_live = i_mem_reg_write && (i_mem_dest != '0);
    assign wb_live  = i_wb_reg_write && (i_wb_dest != '0);

    // youngest producer wins
    function automatic exec_pkg::fwd_sel_e pick_source(
        input logic [exec_pkg::REG_ADDR_W-1:0] src
    );
        exec_pkg::fwd_sel_e sel;
        if (mem_live && (i_mem_dest == src)) begin
            sel = exec_pkg::FWD_MEM;
        end else if (wb_live && (i_wb_dest == src)) begin
            sel = exec_pkg::FWD_WB;
        end else begin
            sel = exec_pkg::FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_rs);
        o_fwd_b = pick_source(i_rt);
    end

endmodule

`default_nettype wire

//--- hdl/instruction_exec.sv
`default_nettype none

module instruction_exec (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_halt,
    input  exec_pkg::id_ex_t                i_id_ex,
    input  exec_pkg::fwd_sel_e              i_fwd_a,
    input  exec_pkg::fwd_sel_e              i_fwd_b,
    input  exec_pkg::wb_t                   i_wb,
    output exec_pkg::ex_mem_t               o_ex_mem,
    output logic [exec_pkg::REG_ADDR_W-1:0] o_reg_dest
);

    exec_pkg::alu_func_e         alu_func;
    logic                        is_jump;
    logic [exec_pkg::DATA_W-1:0] operand_a;
    logic [exec_pkg::DATA_W-1:0] fwd_operand_b;
    logic [exec_pkg::DATA_W-1:0] operand_b;
    logic [exec_pkg::DATA_W-1:0] alu_result;

    alu u_alu (
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_func      (alu_func),
        .i_shamt     (i_id_ex.shamt),
        .o_result    (alu_result)
    );

    // alu control
    always_comb begin
        case (i_id_ex.ex_ctl.alu_op)
            exec_pkg::ALUOP_ADD:    alu_func = exec_pkg::FN_ADD;
            exec_pkg::ALUOP_FUNCT:  alu_func = exec_pkg::alu_func_e'(i_id_ex.funct);
            exec_pkg::ALUOP_OPCODE: alu_func = exec_pkg::alu_func_e'(i_id_ex.opcode);
            default:                alu_func = exec_pkg::FN_IDLE;
        endcase
    end

    // jal and jalr take ra/rb straight from decode
    assign is_jump = (i_id_ex.opcode == exec_pkg::OPC_JAL) ||
                     ((i_id_ex.opcode == exec_pkg::OPC_R_TYPE) &&
                      (i_id_ex.funct == exec_pkg::FUNCT_JALR));

    function automatic logic [exec_pkg::DATA_W-1:0] fwd_mux(
        input exec_pkg::fwd_sel_e          sel,
        input logic [exec_pkg::DATA_W-1:0] raw
    );
        logic [exec_pkg::DATA_W-1:0] val;
        case (sel)
            exec_pkg::FWD_MEM: val = o_ex_mem.alu_result;
            exec_pkg::FWD_WB:  val = i_wb.value;
            default:           val = raw;
        endcase
        return val;
    endfunction

    always_comb begin
        operand_a     = is_jump ? i_id_ex.ra : fwd_mux(i_fwd_a, i_id_ex.ra);
        fwd_operand_b = is_jump ? i_id_ex.rb : fwd_mux(i_fwd_b, i_id_ex.rb);
        // immediate only feeds the alu, store data keeps the register value
        operand_b     = i_id_ex.ex_ctl.alu_src ? i_id_ex.immediate : fwd_operand_b;
    end

    // also goes out for a hazard unit
    assign o_reg_dest = i_id_ex.ex_ctl.reg_dest ? i_id_ex.rd : i_id_ex.rt;

    // ex/mem register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_mem <= '0;
        end else if (!i_halt) begin
            o_ex_mem.mem_ctl    <= i_id_ex.mem_ctl;
            o_ex_mem.wb_ctl     <= i_id_ex.wb_ctl;
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.store_data <= fwd_operand_b;
            o_ex_mem.reg_dest   <= o_reg_dest;
        end
    end

    // forward unit must never emit the spare code
    a_fwd_a_legal: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fwd_a != 2'd3);
    a_fwd_b_legal: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fwd_b != 2'd3);

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_halt,
    input  exec_pkg::ex_mem_t i_ex_mem,
    output exec_pkg::wb_t     o_wb
);

    logic [exec_pkg::DATA_W-1:0]      dmem [exec_pkg::DMEM_WORDS];
    logic [exec_pkg::DMEM_ADDR_W-1:0] word_idx;
    logic [1:0]                       byte_off;
    logic [3:0]                       byte_en;
    logic [exec_pkg::DATA_W-1:0]      wr_data;
    logic [exec_pkg::DATA_W-1:0]      rd_word;
    logic [7:0]                       rd_byte;
    logic [15:0]                      rd_half;
    logic [exec_pkg::DATA_W-1:0]      load_value;
    logic                             sign_fill;

    assign word_idx = i_ex_mem.alu_result[exec_pkg::DMEM_ADDR_W+1:2];
    assign byte_off = i_ex_mem.alu_result[1:0];

    // replicate store data across lanes, enables pick the lane
    always_comb begin
        case (i_ex_mem.mem_ctl.width)
            exec_pkg::MW_BYTE: begin
                byte_en = 4'b0001 << byte_off;
                wr_data = {4{i_ex_mem.store_data[7:0]}};
            end
            exec_pkg::MW_HALF: begin
                byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{i_ex_mem.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = i_ex_mem.store_data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.mem_ctl.mem_write && !i_halt) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // combinational read and extension
    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[8*byte_off +: 8];
    assign rd_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (i_ex_mem.mem_ctl.width)
            exec_pkg::MW_BYTE: begin
                sign_fill  = !i_ex_mem.mem_ctl.is_unsigned && rd_byte[7];
                load_value = {{24{sign_fill}}, rd_byte};
            end
            exec_pkg::MW_HALF: begin
                sign_fill  = !i_ex_mem.mem_ctl.is_unsigned && rd_half[15];
                load_value = {{16{sign_fill}}, rd_half};
            end
            default: begin
                sign_fill  = 1'b0;
                load_value = rd_word;
            end
        endcase
    end

    // mem/wb register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb <= '0;
        end else if (!i_halt) begin
            o_wb.reg_write <= i_ex_mem.wb_ctl.reg_write;
            o_wb.reg_dest  <= i_ex_mem.reg_dest;
            o_wb.value     <= i_ex_mem.wb_ctl.mem_to_reg ? load_value : i_ex_mem.alu_result;
        end
    end

    a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_ex_mem.mem_ctl.mem_read && i_ex_mem.mem_ctl.mem_write));

    // decode and ex together must produce aligned addresses
    a_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_ex_mem.mem_ctl.mem_read || i_ex_mem.mem_ctl.mem_write) |->
        ((i_ex_mem.mem_ctl.width == exec_pkg::MW_BYTE) ||
         (i_ex_mem.mem_ctl.width == exec_pkg::MW_HALF && !byte_off[0]) ||
         (byte_off == 2'b00)));

endmodule

`default_nettype wire

//--- hdl/exec_backend.sv
`default_nettype none

module exec_backend (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_halt,
    input  exec_pkg::id_ex_t                i_id_ex,
    output exec_pkg::wb_t                   o_wb,
    output logic [exec_pkg::REG_ADDR_W-1:0] o_reg_dest
);

    exec_pkg::ex_mem_t  ex_mem;
    exec_pkg::fwd_sel_e fwd_a;
    exec_pkg::fwd_sel_e fwd_b;

    // sources compared against the two younger stages
    forward_unit u_forward_unit (
        .i_rs            (i_id_ex.rs),
        .i_rt            (i_id_ex.rt),
        .i_mem_dest      (ex_mem.reg_dest),
        .i_mem_reg_write (ex_mem.wb_ctl.reg_write),
        .i_wb_dest       (o_wb.reg_dest),
        .i_wb_reg_write  (o_wb.reg_write),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    instruction_exec u_instruction_exec (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_id_ex    (i_id_ex),
        .i_fwd_a    (fwd_a),
        .i_fwd_b    (fwd_b),
        .i_wb       (o_wb),
        .o_ex_mem   (ex_mem),
        .o_reg_dest (o_reg_dest)
    );

    mem_stage u_mem_stage (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_halt   (i_halt),
        .i_ex_mem (ex_mem),
        .o_wb     (o_wb)
    );

endmodule

`default_nettype wire

//--- test/exec_backend_tb.sv
`default_nettype none

module exec_backend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS       = 39;
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 8;
    // each row takes one issue cycle plus at most two halt cycles
    localparam int WDOG_CYCLES = RST_CYCLES + (ROWS + 2) * 4;

    typedef struct packed {
        exec_pkg::id_ex_t id;
        logic             use_link;
        logic [31:0]      link;
        logic             exp_we;
        logic [4:0]       exp_dest;
        logic [31:0]      exp_val;
    } row_t;

    logic              i_clk;
    logic              i_reset;
    logic              i_halt;
    exec_pkg::id_ex_t  i_id_ex;
    exec_pkg::wb_t     o_wb;
    logic [4:0]        o_reg_dest;

    row_t        rows [ROWS];
    logic [31:0] shadow [32];
    integer      seed;
    int          error_count;
    int          ex_slot;
    int          wb_slot;
    int          prev_tag;
    logic        prev_halt;

    exec_backend i_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_id_ex    (i_id_ex),
        .o_wb       (o_wb),
        .o_reg_dest (o_reg_dest)
    );

    always #(PERIOD / 2) i_clk = ~i_clk;

    function automatic row_t expect_write(input row_t r, input int dest, input logic [31:0] val);
        row_t e;
        e = r;
        e.exp_we = 1'b1;
        e.exp_dest = 5'(dest);
        e.exp_val = val;
        return e;
    endfunction

    function automatic row_t r_op(input exec_pkg::alu_func_e fn, input int rd, input int rs,
                                  input int rt, input int sh, input logic [31:0] val);
        row_t r;
        r = '0;
        r.id.ex_ctl.reg_dest = 1'b1;
        r.id.ex_ctl.alu_op = exec_pkg::ALUOP_FUNCT;
        r.id.wb_ctl.reg_write = 1'b1;
        r.id.funct = fn;
        r.id.rd = 5'(rd);
        r.id.rs = 5'(rs);
        r.id.rt = 5'(rt);
        r.id.shamt = 5'(sh);
        return expect_write(r, rd, val);
    endfunction

    function automatic row_t i_op(input exec_pkg::alu_func_e fn, input int rt, input int rs,
                                  input logic [31:0] imm, input logic [31:0] val);
        row_t r;
        r = '0;
        r.id.ex_ctl.alu_src = 1'b1;
        r.id.ex_ctl.alu_op = exec_pkg::ALUOP_OPCODE;
        r.id.wb_ctl.reg_write = 1'b1;
        r.id.opcode = fn;
        r.id.rs = 5'(rs);
        r.id.rt = 5'(rt);
        r.id.immediate = imm;
        return expect_write(r, rt, val);
    endfunction

    function automatic row_t mem_op(input logic is_load, input exec_pkg::mem_width_e width,
                                    input logic uns, input int rt, input int rs,
                                    input logic [31:0] imm, input logic [31:0] val);
        row_t r;
        r = '0;
        r.id.opcode = is_load ? 6'b100011 : 6'b101011;
        r.id.ex_ctl.alu_src = 1'b1;
        r.id.ex_ctl.alu_op = exec_pkg::ALUOP_ADD;
        r.id.mem_ctl.mem_read = is_load;
        r.id.mem_ctl.mem_write = !is_load;
        r.id.mem_ctl.is_unsigned = uns;
        r.id.mem_ctl.width = width;
        r.id.wb_ctl.mem_to_reg = is_load;
        r.id.wb_ctl.reg_write = is_load;
        r.id.rs = 5'(rs);
        r.id.rt = 5'(rt);
        r.id.immediate = imm;
        if (is_load) begin
            r = expect_write(r, rt, val);
        end
        return r;
    endfunction

    // link value arrives in ra, rs and rt still carry the raw fields
    function automatic row_t jump_op(input logic is_jalr, input int rd, input int rs,
                                     input int rt, input logic [31:0] link);
        row_t r;
        r = '0;
        r.id.opcode = is_jalr ? exec_pkg::OPC_R_TYPE : exec_pkg::OPC_JAL;
        r.id.funct = is_jalr ? exec_pkg::FUNCT_JALR : 6'b000000;
        r.id.ex_ctl.reg_dest = 1'b1;
        r.id.ex_ctl.alu_op = exec_pkg::ALUOP_ADD;
        r.id.wb_ctl.reg_write = 1'b1;
        r.id.rd = 5'(rd);
        r.id.rs = 5'(rs);
        r.id.rt = 5'(rt);
        r.use_link = 1'b1;
        r.link = link;
        return expect_write(r, rd, link);
    endfunction

    function automatic row_t branch_op(input int rs, input int rt);
        row_t r;
        r = '0;
        r.id.opcode = 6'b000100;
        r.id.ex_ctl.alu_op = exec_pkg::ALUOP_IDLE;
        r.id.rs = 5'(rs);
        r.id.rt = 5'(rt);
        return r;
    endfunction

    task automatic load_rows();
        rows[0]  = '0;
        rows[1]  = i_op(exec_pkg::FN_ADDI, 1, 0, 32'd100, 32'h0000_0064);
        rows[2]  = i_op(exec_pkg::FN_ADDI, 2, 0, 32'hFFFF_FFFD, 32'hFFFF_FFFD);
        // r1 from mem/wb, r2 from ex/mem
        rows[3]  = r_op(exec_pkg::FN_ADD, 3, 1, 2, 0, 32'h0000_0061);
        rows[4]  = r_op(exec_pkg::FN_SUB, 4, 3, 1, 0, 32'hFFFF_FFFD);
        rows[5]  = r_op(exec_pkg::FN_SLT, 5, 4, 1, 0, 32'h0000_0001);
        rows[6]  = r_op(exec_pkg::FN_SLTU, 6, 4, 1, 0, 32'h0000_0000);
        rows[7]  = r_op(exec_pkg::FN_SLL, 7, 0, 1, 4, 32'h0000_0640);
        rows[8]  = r_op(exec_pkg::FN_SRA, 8, 0, 2, 1, 32'hFFFF_FFFE);
        rows[9]  = r_op(exec_pkg::FN_SRL, 9, 0, 2, 28, 32'h0000_000F);
        rows[10] = r_op(exec_pkg::FN_SLLV, 10, 9, 1, 0, 32'h0032_0000);
        rows[11] = r_op(exec_pkg::FN_SRAV, 11, 5, 2, 0, 32'hFFFF_FFFE);
        rows[12] = i_op(exec_pkg::FN_LUI, 12, 0, 32'h0000_ABCD, 32'hABCD_0000);
        rows[13] = i_op(exec_pkg::FN_ORI, 12, 12, 32'h0000_1234, 32'hABCD_1234);
        // r12 sits in both stages, the younger copy must win
        rows[14] = i_op(exec_pkg::FN_ANDI, 13, 12, 32'h0000_FF0F, 32'h0000_1204);
        rows[15] = i_op(exec_pkg::FN_XORI, 14, 13, 32'hFFFF_FFFF, 32'hFFFF_EDFB);
        rows[16] = i_op(exec_pkg::FN_SLTI, 15, 14, 32'h0000_0000, 32'h0000_0001);
        rows[17] = i_op(exec_pkg::FN_SLTIU, 16, 1, 32'hFFFF_FFFF, 32'h0000_0001);
        rows[18] = r_op(exec_pkg::FN_NOR, 17, 1, 2, 0, 32'h0000_0002);
        rows[19] = r_op(exec_pkg::FN_XOR, 18, 12, 14, 0, 32'h5432_FFCF);
        rows[20] = r_op(exec_pkg::FN_AND, 19, 12, 18, 0, 32'h0000_1204);
        rows[21] = mem_op(1'b0, exec_pkg::MW_WORD, 1'b0, 12, 0, 32'd8, '0);
        rows[22] = i_op(exec_pkg::FN_ADDI, 20, 0, 32'h0000_0180, 32'h0000_0180);
        // store data for r20 only exists in ex/mem
        rows[23] = mem_op(1'b0, exec_pkg::MW_BYTE, 1'b0, 20, 0, 32'd13, '0);
        rows[24] = mem_op(1'b0, exec_pkg::MW_HALF, 1'b0, 2, 0, 32'd18, '0);
        rows[25] = mem_op(1'b1, exec_pkg::MW_WORD, 1'b0, 21, 0, 32'd8, 32'hABCD_1234);
        rows[26] = mem_op(1'b1, exec_pkg::MW_BYTE, 1'b0, 22, 0, 32'd13, 32'hFFFF_FF80);
        rows[27] = mem_op(1'b1, exec_pkg::MW_BYTE, 1'b1, 23, 0, 32'd13, 32'h0000_0080);
        rows[28] = mem_op(1'b1, exec_pkg::MW_HALF, 1'b0, 24, 0, 32'd18, 32'hFFFF_FFFD);
        rows[29] = mem_op(1'b1, exec_pkg::MW_HALF, 1'b1, 25, 0, 32'd18, 32'h0000_FFFD);
        rows[30] = mem_op(1'b1, exec_pkg::MW_BYTE, 1'b1, 26, 0, 32'd10, 32'h0000_00CD);
        rows[31] = i_op(exec_pkg::FN_ADDI, 27, 0, 32'd7, 32'h0000_0007);
        rows[32] = jump_op(1'b0, 31, 27, 0, 32'h0040_0100);
        rows[33] = jump_op(1'b1, 28, 27, 31, 32'h0040_0200);
        rows[34] = branch_op(28, 31);
        rows[35] = r_op(exec_pkg::FN_ADD, 29, 31, 28, 0, 32'h0080_0300);
        // a write to r0 must not be forwarded
        rows[36] = i_op(exec_pkg::FN_ADDI, 0, 0, 32'd5, 32'h0000_0005);
        rows[37] = r_op(exec_pkg::FN_ADD, 30, 0, 0, 0, 32'h0000_0000);
        rows[38] = '0;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_wb();
        if (wb_slot < 0) begin
            check(32'(o_wb.reg_write), 32'd0, "reg_write for a bubble");
        end else begin
            check(32'(o_wb.reg_write), 32'(rows[wb_slot].exp_we),
                  $sformatf("row %0d reg_write", wb_slot));
            if (rows[wb_slot].exp_we) begin
                check(32'(o_wb.reg_dest), 32'(rows[wb_slot].exp_dest),
                      $sformatf("row %0d reg_dest", wb_slot));
                check(o_wb.value, rows[wb_slot].exp_val, $sformatf("row %0d value", wb_slot));
            end
        end
        // register file update, only real writes
        if (o_wb.reg_write && o_wb.reg_dest != 5'd0) begin
            shadow[o_wb.reg_dest] = o_wb.value;
        end
    endtask

    // one clock: drive on the rising edge, observe at the falling edge
    task automatic step(input exec_pkg::id_ex_t id, input logic halt, input int tag);
        @(posedge i_clk);
        i_id_ex <= id;
        i_halt <= halt;
        @(negedge i_clk);
        if (!prev_halt) begin
            wb_slot = ex_slot;
            ex_slot = prev_tag;
        end
        prev_halt = halt;
        prev_tag = tag;
        check_wb();
        // destination seen by a hazard unit for the row on the bus
        if (tag >= 0) begin
            if (rows[tag].exp_we) begin
                check(32'(o_reg_dest), 32'(rows[tag].exp_dest),
                      $sformatf("row %0d o_reg_dest", tag));
            end
        end
    endtask

    initial begin
        #(WDOG_CYCLES * PERIOD);
        $display("simulation hung: watchdog timer expired before the test finished");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        exec_pkg::id_ex_t id;
        int halt_cycles;
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_halt = 1'b0;
        i_id_ex = '0;
        seed = 32'hc517e51a;
        error_count = 0;
        ex_slot = -1;
        wb_slot = -1;
        prev_tag = -1;
        prev_halt = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        load_rows();
        repeat (RST_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check(32'(o_wb.reg_write), 32'd0, "reg_write after reset");

        // two trailing bubbles drain the pipeline
        for (int j = 0; j < ROWS + 2; j++) begin
            id = '0;
            // operands read from the register file ahead of any stall
            if (j < ROWS) begin
                id = rows[j].id;
                id.ra = rows[j].use_link ? rows[j].link : shadow[id.rs];
                id.rb = rows[j].use_link ? 32'd0 : shadow[id.rt];
            end
            halt_cycles = $unsigned($random(seed)) % 3;
            for (int k = 0; k < halt_cycles; k++) begin
                step(i_id_ex, 1'b1, prev_tag);
            end
            step(id, 1'b0, (j < ROWS) ? j : -1);
        end

        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_backend.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/forward_unit.sv
hdl/instruction_exec.sv
hdl/mem_stage.sv
hdl/exec_backend.sv
test/exec_backend_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module exec_backend_tb -f exec_backend.f -o sim_exec_backend

./obj_dir/sim_exec_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
